// File: hdl/adderStations.sv
`timescale 1ns/1ps

module adderStations #(
    parameter int StationCount = 6
) (
    input  logic                              clock,
    input  logic                              rstN,
    input  logic                              issue,
    input  logic [StationCount-1:0]           issueTag,
    input  tomasuloPkg::aluOpT                operation,
    input  logic [tomasuloPkg::DATA_W-1:0]    aValue,
    input  logic [StationCount-1:0]           aTag,
    input  logic [tomasuloPkg::DATA_W-1:0]    bValue,
    input  logic [StationCount-1:0]           bTag,
    output logic [StationCount-1:0]           stationFree,
    output logic                              dispatch,
    output logic [StationCount-1:0]           dispatchTag,
    output tomasuloPkg::aluOpT                dispatchOp,
    output logic [tomasuloPkg::DATA_W-1:0]    dispatchA,
    output logic [tomasuloPkg::DATA_W-1:0]    dispatchB,
    input  logic                              cdbValid,
    input  logic [StationCount-1:0]           cdbTag,
    input  logic [tomasuloPkg::DATA_W-1:0]    cdbValue
);

    logic [StationCount-1:0]        busyQ;
    logic [StationCount-1:0]        pendQ;
    logic [StationCount-1:0]        opsReady;
    tomasuloPkg::aluOpT             opQ   [StationCount];
    logic [tomasuloPkg::DATA_W-1:0] aValQ [StationCount];
    logic [tomasuloPkg::DATA_W-1:0] bValQ [StationCount];
    logic [StationCount-1:0]        aTagQ [StationCount];
    logic [StationCount-1:0]        bTagQ [StationCount];

    // A station keeps its tag until the bus carries its result,
    // so no other instruction can be renamed to it while in flight
    assign stationFree = ~busyQ;

    always_comb begin
        for (int s = 0; s < StationCount; s++) begin
            opsReady[s] = pendQ[s] && aTagQ[s] == '0 && bTagQ[s] == '0;
        end
    end

    assign dispatch = |opsReady;

    // Lowest index ready station wins
    always_comb begin
        dispatchTag = '0;
        dispatchOp  = tomasuloPkg::ALU_ADD;
        dispatchA   = '0;
        dispatchB   = '0;
        for (int s = StationCount - 1; s >= 0; s--) begin
            if (opsReady[s]) begin
                dispatchTag    = '0;
                dispatchTag[s] = 1'b1;
                dispatchOp     = opQ[s];
                dispatchA      = aValQ[s];
                dispatchB      = bValQ[s];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            busyQ <= '0;
            pendQ <= '0;
        end else begin
            for (int s = 0; s < StationCount; s++) begin
                if (cdbValid && cdbTag[s]) begin
                    busyQ[s] <= 1'b0;
                end
                if (dispatch && dispatchTag[s]) begin
                    pendQ[s] <= 1'b0;
                end
                if (issue && issueTag[s]) begin
                    busyQ[s] <= 1'b1;
                    pendQ[s] <= 1'b1;
                end
            end
        end
    end

    // Operand capture and wakeup on bus tags
    always_ff @(posedge clock) begin
        for (int s = 0; s < StationCount; s++) begin
            if (cdbValid && aTagQ[s] == cdbTag) begin
                aValQ[s] <= cdbValue;
                aTagQ[s] <= '0;
            end
            if (cdbValid && bTagQ[s] == cdbTag) begin
                bValQ[s] <= cdbValue;
                bTagQ[s] <= '0;
            end
            if (issue && issueTag[s]) begin
                opQ[s]   <= operation;
                aValQ[s] <= aValue;
                aTagQ[s] <= aTag;
                bValQ[s] <= bValue;
                bTagQ[s] <= bTag;
            end
        end
    end

    noOverwriteA: assert property (@(posedge clock) disable iff (!rstN)
        issue |-> (issueTag & busyQ) == '0);

endmodule

// File: hdl/instructionQueue.sv
`timescale 1ns/1ps

module instructionQueue #(
    parameter int QueueDepth   = 8,
    parameter int StationCount = 6,
    parameter int ProgramDepth = 1024
) (
    input  logic                                  clock,
    input  logic                                  rstN,
    input  logic                                  start,
    input  logic [$clog2(ProgramDepth):0]         programLength,
    output logic [$clog2(ProgramDepth)-1:0]       fetchAddr,
    input  logic [tomasuloPkg::INSTR_W-1:0]       fetchData,
    input  logic [StationCount-1:0]               stationFree,
    output logic                                  issue,
    output logic [StationCount-1:0]               issueTag,
    output tomasuloPkg::aluOpT                    operation,
    output logic [tomasuloPkg::REG_ADDR_W-1:0]    destAddr,
    output logic [tomasuloPkg::REG_ADDR_W-1:0]    aAddr,
    output logic [tomasuloPkg::REG_ADDR_W-1:0]    bAddr,
    input  logic                                  dispatch,
    input  logic [StationCount-1:0]               dispatchTag,
    input  logic                                  cdbValid,
    input  logic [StationCount-1:0]               cdbTag,
    output logic                                  busy
);

    localparam int IdxW   = $clog2(QueueDepth);
    localparam int CountW = $clog2(QueueDepth + 1);
    localparam int PcW    = $clog2(ProgramDepth) + 1;

    logic [tomasuloPkg::INSTR_W-1:0] instrQ [QueueDepth];
    tomasuloPkg::entryStateT         stateQ [QueueDepth];
    logic [StationCount-1:0]         tagQ   [QueueDepth];

    tomasuloPkg::entryStateT         updState   [QueueDepth];
    logic [StationCount-1:0]         updTag     [QueueDepth];
    tomasuloPkg::entryStateT         shiftState [QueueDepth];
    logic [StationCount-1:0]         shiftTag   [QueueDepth];
    logic [tomasuloPkg::INSTR_W-1:0] shiftInstr [QueueDepth];

    logic [PcW-1:0]    pc;
    logic [PcW-1:0]    lengthQ;
    logic [CountW-1:0] count;
    logic [CountW:0]   occupancy;
    logic [IdxW-1:0]   tailIdx;
    logic              fetchGo;
    logic              fetchValid;

    logic            issueFound;
    logic [IdxW-1:0] issueIdx;
    logic            removing;
    logic [IdxW-1:0] removeIdx;
    logic            tagClash;

    logic [tomasuloPkg::INSTR_W-1:0]                     issueWord;
    logic [tomasuloPkg::OP_HI-tomasuloPkg::OP_LO:0]      opField;

    // Count the word arriving from memory so the window never overflows
    assign occupancy = {1'b0, count} + {{CountW{1'b0}}, fetchValid};
    assign fetchGo   = busy && (pc < lengthQ) && (occupancy < (CountW + 1)'(QueueDepth));
    assign fetchAddr = pc[PcW-2:0];
    assign tailIdx   = IdxW'(count - CountW'(removing));

    // Oldest waiting entry and the completing entry
    always_comb begin
        issueFound = 1'b0;
        issueIdx   = '0;
        removing   = 1'b0;
        removeIdx  = '0;
        for (int i = QueueDepth - 1; i >= 0; i--) begin
            if (stateQ[i] == tomasuloPkg::WAITING) begin
                issueFound = 1'b1;
                issueIdx   = IdxW'(i);
            end
            if (cdbValid && stateQ[i] == tomasuloPkg::EXECUTING && tagQ[i] == cdbTag) begin
                removing  = 1'b1;
                removeIdx = IdxW'(i);
            end
        end
    end

    assign issueWord = instrQ[issueIdx];
    assign opField   = issueWord[tomasuloPkg::OP_HI:tomasuloPkg::OP_LO];
    assign operation = tomasuloPkg::aluOpT'(opField[2:0]);
    assign destAddr  = issueWord[tomasuloPkg::DEST_HI:tomasuloPkg::DEST_LO];
    assign aAddr     = issueWord[tomasuloPkg::SRC_A_HI:tomasuloPkg::SRC_A_LO];
    assign bAddr     = issueWord[tomasuloPkg::SRC_B_HI:tomasuloPkg::SRC_B_LO];
    assign issue     = issueFound && (|stationFree);
    // Lowest free station, one-hot
    assign issueTag  = stationFree & (~stationFree + 1'b1);

    // State changes first, then compaction over the completed entry
    always_comb begin
        for (int i = 0; i < QueueDepth; i++) begin
            updState[i] = stateQ[i];
            updTag[i]   = tagQ[i];
            if (issue && i == int'(issueIdx)) begin
                updState[i] = tomasuloPkg::ISSUED;
                updTag[i]   = issueTag;
            end
            if (dispatch && stateQ[i] == tomasuloPkg::ISSUED && tagQ[i] == dispatchTag) begin
                updState[i] = tomasuloPkg::EXECUTING;
            end
        end
        for (int i = 0; i < QueueDepth; i++) begin
            shiftState[i] = updState[i];
            shiftTag[i]   = updTag[i];
            shiftInstr[i] = instrQ[i];
            if (removing && i >= int'(removeIdx)) begin
                if (i == QueueDepth - 1) begin
                    shiftState[i] = tomasuloPkg::EMPTY;
                    shiftTag[i]   = '0;
                end else begin
                    shiftState[i] = updState[i + 1];
                    shiftTag[i]   = updTag[i + 1];
                    shiftInstr[i] = instrQ[i + 1];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc         <= '0;
            lengthQ    <= '0;
            count      <= '0;
            busy       <= 1'b0;
            fetchValid <= 1'b0;
            for (int i = 0; i < QueueDepth; i++) begin
                stateQ[i] <= tomasuloPkg::EMPTY;
                tagQ[i]   <= '0;
            end
        end else begin
            fetchValid <= fetchGo;
            if (fetchGo) begin
                pc <= pc + 1'b1;
            end
            if (start) begin
                pc      <= '0;
                lengthQ <= programLength;
                busy    <= 1'b1;
            end else if (busy && count == '0 && !fetchValid && pc >= lengthQ) begin
                busy <= 1'b0;
            end
            count <= count + CountW'(fetchValid) - CountW'(removing);
            for (int i = 0; i < QueueDepth; i++) begin
                stateQ[i] <= shiftState[i];
                tagQ[i]   <= shiftTag[i];
            end
            if (fetchValid) begin
                stateQ[tailIdx] <= tomasuloPkg::WAITING;
                tagQ[tailIdx]   <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < QueueDepth; i++) begin
            instrQ[i] <= shiftInstr[i];
        end
        if (fetchValid) begin
            instrQ[tailIdx] <= fetchData;
        end
    end

    always_comb begin
        tagClash = 1'b0;
        for (int i = 0; i < QueueDepth; i++) begin
            for (int j = i + 1; j < QueueDepth; j++) begin
                if ((stateQ[i] == tomasuloPkg::ISSUED || stateQ[i] == tomasuloPkg::EXECUTING) &&
                    (stateQ[j] == tomasuloPkg::ISSUED || stateQ[j] == tomasuloPkg::EXECUTING) &&
                    tagQ[i] == tagQ[j]) begin
                    tagClash = 1'b1;
                end
            end
        end
    end

    // A station tag stays bound to one entry until its result is broadcast
    uniqueTagA: assert property (@(posedge clock) disable iff (!rstN) !tagClash);

    adderOnlyA: assert property (@(posedge clock) disable iff (!rstN)
        issue |-> issueWord[tomasuloPkg::UNIT_HI:tomasuloPkg::UNIT_LO] == tomasuloPkg::UNIT_ADDER);

endmodule

// File: hdl/integerAdder.sv
`timescale 1ns/1ps

module integerAdder #(
    parameter int StationCount = 6
) (
    input  logic                              clock,
    input  logic                              rstN,
    input  logic                              dispatch,
    input  logic [StationCount-1:0]           dispatchTag,
    input  tomasuloPkg::aluOpT                dispatchOp,
    input  logic [tomasuloPkg::DATA_W-1:0]    dispatchA,
    input  logic [tomasuloPkg::DATA_W-1:0]    dispatchB,
    output logic                              cdbValid,
    output logic [StationCount-1:0]           cdbTag,
    output logic [tomasuloPkg::DATA_W-1:0]    cdbValue
);

    logic                           s1Valid;
    logic [StationCount-1:0]        s1Tag;
    tomasuloPkg::aluOpT             s1Op;
    logic [tomasuloPkg::DATA_W-1:0] s1A;
    logic [tomasuloPkg::DATA_W-1:0] s1B;
    logic [tomasuloPkg::DATA_W-1:0] result;

    always_comb begin
        case (s1Op)
            tomasuloPkg::ALU_ADD: result = s1A + s1B;
            tomasuloPkg::ALU_SUB: result = s1A - s1B;
            tomasuloPkg::ALU_OR:  result = s1A | s1B;
            tomasuloPkg::ALU_AND: result = s1A & s1B;
            // Only A is used
            tomasuloPkg::ALU_NOT: result = ~s1A;
            tomasuloPkg::ALU_XOR: result = s1A ^ s1B;
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            s1Valid  <= 1'b0;
            cdbValid <= 1'b0;
        end else begin
            s1Valid  <= dispatch;
            cdbValid <= s1Valid;
        end
    end

    // Stage 1 holds operands, stage 2 drives the bus
    always_ff @(posedge clock) begin
        s1Tag    <= dispatchTag;
        s1Op     <= dispatchOp;
        s1A      <= dispatchA;
        s1B      <= dispatchB;
        cdbTag   <= s1Tag;
        cdbValue <= result;
    end

endmodule

// File: hdl/programMemory.sv
`timescale 1ns/1ps

module programMemory #(
    parameter int ProgramDepth = 1024
) (
    input  logic                                clock,
    input  logic                                progWrite,
    input  logic [$clog2(ProgramDepth)-1:0]     progAddr,
    input  logic [tomasuloPkg::INSTR_W-1:0]     progData,
    input  logic [$clog2(ProgramDepth)-1:0]     fetchAddr,
    output logic [tomasuloPkg::INSTR_W-1:0]     fetchData
);

    logic [tomasuloPkg::INSTR_W-1:0] words [ProgramDepth];

    // One cycle read latency on the fetch side
    always_ff @(posedge clock) begin
        if (progWrite) begin
            words[progAddr] <= progData;
        end
        fetchData <= words[fetchAddr];
    end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int StationCount = 6
) (
    input  logic                                  clock,
    input  logic                                  rstN,
    input  logic                                  regWrite,
    input  logic [tomasuloPkg::REG_ADDR_W-1:0]    regWriteAddr,
    input  logic [tomasuloPkg::DATA_W-1:0]        regWriteData,
    input  logic [tomasuloPkg::REG_ADDR_W-1:0]    regReadAddr,
    output logic [tomasuloPkg::DATA_W-1:0]        regReadData,
    input  logic [tomasuloPkg::REG_ADDR_W-1:0]    aAddr,
    input  logic [tomasuloPkg::REG_ADDR_W-1:0]    bAddr,
    output logic [tomasuloPkg::DATA_W-1:0]        aValue,
    output logic [StationCount-1:0]               aTag,
    output logic [tomasuloPkg::DATA_W-1:0]        bValue,
    output logic [StationCount-1:0]               bTag,
    input  logic                                  issue,
    input  logic [tomasuloPkg::REG_ADDR_W-1:0]    destAddr,
    input  logic [StationCount-1:0]               issueTag,
    input  logic                                  cdbValid,
    input  logic [StationCount-1:0]               cdbTag,
    input  logic [tomasuloPkg::DATA_W-1:0]        cdbValue
);

    localparam int RegCount = 2 ** tomasuloPkg::REG_ADDR_W;

    logic [tomasuloPkg::DATA_W-1:0] values [RegCount];
    // Zero tag means the value is ready
    logic [StationCount-1:0]        tags   [RegCount];

    assign regReadData = values[regReadAddr];

    // Source reads see a result broadcast in the same cycle
    always_comb begin
        aValue = values[aAddr];
        aTag   = tags[aAddr];
        bValue = values[bAddr];
        bTag   = tags[bAddr];
        if (cdbValid && tags[aAddr] == cdbTag) begin
            aValue = cdbValue;
            aTag   = '0;
        end
        if (cdbValid && tags[bAddr] == cdbTag) begin
            bValue = cdbValue;
            bTag   = '0;
        end
    end

    always_ff @(posedge clock) begin
        for (int r = 0; r < RegCount; r++) begin
            if (cdbValid && tags[r] == cdbTag) begin
                values[r] <= cdbValue;
            end
        end
        if (regWrite) begin
            values[regWriteAddr] <= regWriteData;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int r = 0; r < RegCount; r++) begin
                tags[r] <= '0;
            end
        end else begin
            for (int r = 0; r < RegCount; r++) begin
                if (cdbValid && tags[r] == cdbTag) begin
                    tags[r] <= '0;
                end
            end
            if (regWrite) begin
                tags[regWriteAddr] <= '0;
            end
            // A new rename beats a write-back to the same register
            if (issue) begin
                tags[destAddr] <= issueTag;
            end
        end
    end

endmodule

// File: hdl/tomasuloCore.sv
`timescale 1ns/1ps

module tomasuloCore #(
    parameter int QueueDepth   = 8,
    parameter int StationCount = 6,
    parameter int ProgramDepth = 1024
) (
    input  logic                                  clock,
    input  logic                                  rstN,
    input  logic                                  progWrite,
    input  logic [$clog2(ProgramDepth)-1:0]       progAddr,
    input  logic [tomasuloPkg::INSTR_W-1:0]       progData,
    input  logic                                  regWrite,
    input  logic [tomasuloPkg::REG_ADDR_W-1:0]    regWriteAddr,
    input  logic [tomasuloPkg::DATA_W-1:0]        regWriteData,
    input  logic [tomasuloPkg::REG_ADDR_W-1:0]    regReadAddr,
    output logic [tomasuloPkg::DATA_W-1:0]        regReadData,
    input  logic                                  start,
    input  logic [$clog2(ProgramDepth):0]         programLength,
    output logic                                  busy
);

    logic [$clog2(ProgramDepth)-1:0]    fetchAddr;
    logic [tomasuloPkg::INSTR_W-1:0]    fetchData;
    logic [StationCount-1:0]            stationFree;
    logic                               issue;
    logic [StationCount-1:0]            issueTag;
    tomasuloPkg::aluOpT                 operation;
    logic [tomasuloPkg::REG_ADDR_W-1:0] destAddr;
    logic [tomasuloPkg::REG_ADDR_W-1:0] aAddr;
    logic [tomasuloPkg::REG_ADDR_W-1:0] bAddr;
    logic [tomasuloPkg::DATA_W-1:0]     aValue;
    logic [StationCount-1:0]            aTag;
    logic [tomasuloPkg::DATA_W-1:0]     bValue;
    logic [StationCount-1:0]            bTag;
    logic                               dispatch;
    logic [StationCount-1:0]            dispatchTag;
    tomasuloPkg::aluOpT                 dispatchOp;
    logic [tomasuloPkg::DATA_W-1:0]     dispatchA;
    logic [tomasuloPkg::DATA_W-1:0]     dispatchB;
    logic                               cdbValid;
    logic [StationCount-1:0]            cdbTag;
    logic [tomasuloPkg::DATA_W-1:0]     cdbValue;
    logic                               progLoad;
    logic                               regLoad;

    // Loads are only accepted while no program runs
    assign progLoad = progWrite && !busy;
    assign regLoad  = regWrite && !busy;

    programMemory #(.ProgramDepth(ProgramDepth)) programMemoryInst (
        .clock(clock), .progWrite(progLoad), .progAddr(progAddr), .progData(progData),
        .fetchAddr(fetchAddr), .fetchData(fetchData)
    );

    instructionQueue #(
        .QueueDepth(QueueDepth), .StationCount(StationCount), .ProgramDepth(ProgramDepth)
    ) instructionQueueInst (
        .clock(clock), .rstN(rstN), .start(start), .programLength(programLength),
        .fetchAddr(fetchAddr), .fetchData(fetchData), .stationFree(stationFree),
        .issue(issue), .issueTag(issueTag), .operation(operation), .destAddr(destAddr),
        .aAddr(aAddr), .bAddr(bAddr), .dispatch(dispatch), .dispatchTag(dispatchTag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .busy(busy)
    );

    registerFile #(.StationCount(StationCount)) registerFileInst (
        .clock(clock), .rstN(rstN), .regWrite(regLoad), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .regReadAddr(regReadAddr), .regReadData(regReadData),
        .aAddr(aAddr), .bAddr(bAddr), .aValue(aValue), .aTag(aTag), .bValue(bValue),
        .bTag(bTag), .issue(issue), .destAddr(destAddr), .issueTag(issueTag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbValue(cdbValue)
    );

    adderStations #(.StationCount(StationCount)) adderStationsInst (
        .clock(clock), .rstN(rstN), .issue(issue), .issueTag(issueTag),
        .operation(operation), .aValue(aValue), .aTag(aTag), .bValue(bValue), .bTag(bTag),
        .stationFree(stationFree), .dispatch(dispatch), .dispatchTag(dispatchTag),
        .dispatchOp(dispatchOp), .dispatchA(dispatchA), .dispatchB(dispatchB),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbValue(cdbValue)
    );

    integerAdder #(.StationCount(StationCount)) integerAdderInst (
        .clock(clock), .rstN(rstN), .dispatch(dispatch), .dispatchTag(dispatchTag),
        .dispatchOp(dispatchOp), .dispatchA(dispatchA), .dispatchB(dispatchB),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbValue(cdbValue)
    );

endmodule

// File: hdl/tomasuloPkg.sv
package tomasuloPkg;

    parameter int REG_ADDR_W = 5;
    parameter int DATA_W     = 32;
    parameter int INSTR_W    = 32;

    // Instruction word fields
    parameter int OP_HI     = 31;
    parameter int OP_LO     = 26;
    parameter int UNIT_HI   = 31;
    parameter int UNIT_LO   = 29;
    parameter int SRC_A_HI  = 25;
    parameter int SRC_A_LO  = 21;
    parameter int SRC_B_HI  = 20;
    parameter int SRC_B_LO  = 16;
    parameter int DEST_HI   = 15;
    parameter int DEST_LO   = 11;

    parameter logic [2:0] UNIT_ADDER = 3'b000;

    // Low three bits of the operation field
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_OR  = 3'b100,
        ALU_AND = 3'b101,
        ALU_NOT = 3'b110,
        ALU_XOR = 3'b111
    } aluOpT;

    typedef enum logic [1:0] {
        EMPTY,
        WAITING,
        ISSUED,
        EXECUTING
    } entryStateT;

endpackage

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tomasuloCoreTb -f tomasuloCore.f -Mdir "$BUILD_DIR" -o tomasuloCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tomasuloCoreSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: test/goldenPrograms.txt
// First word: record count. Each record: mode (0 loads registers, 1 keeps them), length,
// then the instruction words, 32 initial and 32 expected register values, all in hex
5
// Dependent chain
0 4
00430800 00252000 00813000 00C43800
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
0 5 2 3 a 5 f 19 8 9 a b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
// All six opcodes, plus a negative difference
0 7
00225000 04225800 10226000 14226800 18227000 1C227800 04418000
0 f0f0 ff0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 f0f0 ff0 0 0 0 0 0 0 0 100e0 e100 fff0 f0 ffff0f0f ff00
ffff1f00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// Write after write on r9 behind a slow producer
0 5
00434000 01084000 01084800 1C854800 01215000
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
0 1 2 3 4 5 6 7 a 1 2 b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
// Twenty instructions in two interleaved chains
0 14
0281A000 06A2A800 0281A000 06A2A800 0281A000 06A2A800 0281A000 06A2A800
0281A000 06A2A800 0281A000 06A2A800 0281A000 06A2A800 0281A000 06A2A800
0281A000 06A2A800 0281A000 06A2A800
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 1e 1 16 17 18 19 1a 1b 1c 1d 1e 1f
// Second run on the registers left by the previous one
1 3
1A80B000 02B4B800 169FC000
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 1e 1 16 17 18 19 1a 1b 1c 1d 1e 1f
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 1e 1 ffffffe1 1f 1e 19 1a 1b 1c 1d 1e 1f

// File: test/tomasuloCoreTb.sv
`timescale 1ns/1ps

module tomasuloCoreTb;

    localparam int QueueDepth   = 8;
    localparam int StationCount = 6;
    localparam int ProgramDepth = 1024;
    localparam int AddrW        = $clog2(ProgramDepth);
    localparam int RegCount     = 32;
    localparam int GoldenWords  = 512;
    localparam int BusyTimeout  = 2000;

    logic             clock;
    logic             rstN;
    logic             progWrite;
    logic [AddrW-1:0] progAddr;
    logic [31:0]      progData;
    logic             regWrite;
    logic [4:0]       regWriteAddr;
    logic [31:0]      regWriteData;
    logic [4:0]       regReadAddr;
    logic [31:0]      regReadData;
    logic             start;
    logic [AddrW:0]   programLength;
    logic             busy;

    logic [31:0] golden [GoldenWords];
    logic [31:0] lfsrState;
    int          idleBudget;
    int          errorCount;
    int          testsRun;
    int          testsWithErrors;
    logic        timedOut;

    tomasuloCore #(
        .QueueDepth(QueueDepth), .StationCount(StationCount), .ProgramDepth(ProgramDepth)
    ) UUT (
        .clock(clock), .rstN(rstN), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .regWrite(regWrite), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .regReadAddr(regReadAddr), .regReadData(regReadData),
        .start(start), .programLength(programLength), .busy(busy)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic nextLfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic string testName(input int index);
        case (index)
            0: return "dependent chain";
            1: return "all opcodes";
            2: return "write after write";
            3: return "long program";
            4: return "second run without reset";
            default: return "extra program";
        endcase
    endfunction

    // Up to 16 idle cycles spread over the loads of one test
    task automatic insertIdleGap();
        if (idleBudget > 0) begin
            if (nextLfsrBit()) begin
                idleBudget--;
                @(negedge clock);
            end
        end
    endtask

    task automatic loadInstruction(input int addr, input logic [31:0] word);
        insertIdleGap();
        @(negedge clock);
        progWrite = 1'b1;
        progAddr  = AddrW'(addr);
        progData  = word;
        @(negedge clock);
        progWrite = 1'b0;
    endtask

    task automatic loadRegister(input int r, input logic [31:0] value);
        insertIdleGap();
        @(negedge clock);
        regWrite     = 1'b1;
        regWriteAddr = 5'(r);
        regWriteData = value;
        @(negedge clock);
        regWrite = 1'b0;
    endtask

    task automatic checkRegister(input int r, input logic [31:0] expected, input string phase);
        @(negedge clock);
        regReadAddr = 5'(r);
        #1;
        if (regReadData !== expected) begin
            $display("FAILED regReadData r%0d %s: expected %h, actual %h",
                     r, phase, expected, regReadData);
            errorCount++;
        end
    endtask

    task automatic runProgram(input int length, output logic finished);
        int cycles;
        @(negedge clock);
        start         = 1'b1;
        programLength = (AddrW + 1)'(length);
        @(negedge clock);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("busy did not rise after start");
            errorCount++;
        end
        cycles = 0;
        while (busy !== 1'b0 && cycles < BusyTimeout) begin
            @(negedge clock);
            cycles++;
        end
        finished = (busy === 1'b0);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            testsWithErrors++;
            $display("%s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        int   pos;
        int   recordCount;
        int   mode;
        int   length;
        int   progBase;
        int   initBase;
        int   expectBase;
        int   errorsBefore;
        logic finished;

        rstN          = 1'b0;
        progWrite     = 1'b0;
        progAddr      = '0;
        progData      = '0;
        regWrite      = 1'b0;
        regWriteAddr  = '0;
        regWriteData  = '0;
        regReadAddr   = '0;
        start         = 1'b0;
        programLength = '0;
        lfsrState       = 32'd85920;
        idleBudget      = 0;
        errorCount      = 0;
        testsRun        = 0;
        testsWithErrors = 0;
        timedOut        = 1'b0;
        $readmemh("test/goldenPrograms.txt", golden);

        repeat (16) @(negedge clock);
        rstN = 1'b1;

        // Core must come out of reset idle
        @(negedge clock);
        errorsBefore = errorCount;
        if (busy !== 1'b0) begin
            $display("busy is not low after reset");
            errorCount++;
        end
        finishTest("reset state", errorsBefore);

        recordCount = 0;
        if ($isunknown(golden[0]) || golden[0] == '0) begin
            $display("golden data file could not be read or holds no programs");
            errorCount++;
        end else begin
            recordCount = golden[0];
        end

        pos = 1;
        for (int t = 0; t < recordCount && !timedOut; t++) begin
            mode         = golden[pos];
            length       = golden[pos + 1];
            progBase     = pos + 2;
            initBase     = progBase + length;
            expectBase   = initBase + RegCount;
            pos          = expectBase + RegCount;
            errorsBefore = errorCount;
            idleBudget   = 16;
            for (int i = 0; i < length; i++) begin
                loadInstruction(i, golden[progBase + i]);
            end
            // Mode 1 runs on the registers the previous program left behind
            if (mode == 0) begin
                for (int r = 0; r < RegCount; r++) begin
                    loadRegister(r, golden[initBase + r]);
                end
            end
            for (int r = 0; r < RegCount; r++) begin
                checkRegister(r, golden[initBase + r], "before start");
            end
            runProgram(length, finished);
            if (!finished) begin
                $display("busy still high %0d cycles after start in %s",
                         BusyTimeout, testName(t));
                errorCount++;
                timedOut = 1'b1;
            end else begin
                for (int r = 0; r < RegCount; r++) begin
                    checkRegister(r, golden[expectBase + r], "after run");
                end
            end
            finishTest(testName(t), errorsBefore);
        end

        $display("Tests run %0d, with errors %0d, total errors %0d",
                 testsRun, testsWithErrors, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tomasuloCore.f
hdl/tomasuloPkg.sv
hdl/programMemory.sv
hdl/instructionQueue.sv
hdl/adderStations.sv
hdl/integerAdder.sv
hdl/registerFile.sv
hdl/tomasuloCore.sv
test/tomasuloCoreTb.sv
